/* verilog/m72_io_pkg.sv */
//====================================================================
// Shared types for the M72 main CPU port block and audio mixer
// Word ports are decoded with address bit 0 masked
//====================================================================
package m72_io_pkg;

    // Port map
    localparam logic [7:0] PORT_SW   = 8'h00;   // Switches word, 0x00/0x01
    localparam logic [7:0] PORT_FLAG = 8'h02;   // Flags word, 0x02/0x03
    localparam logic [7:0] PORT_DSW  = 8'h04;   // DIP word, 0x04/0x05
    localparam logic [7:0] PORT_FSET = 8'h00;   // Flag register write

    localparam logic [7:0] IO_IDLE_BYTE = 8'hFF;

    // One CPU port bus cycle
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [7:0] addr;
        logic [7:0] data;
    } io_req_t;

    // Decoded request
    typedef struct packed {
        logic       rd;
        logic       wr;
        logic       sel_sw;
        logic       sel_flag;
        logic       sel_dsw;
        logic       sel_fset;
        logic       sel_mculatch;
        logic       hi_byte;
        logic [7:0] wdata;
    } io_sel_t;

    typedef struct packed {
        logic [1:0] coin;
        logic [1:0] start;
        logic [3:0] p1_joystick;
        logic [3:0] p2_joystick;
        logic [3:0] p1_buttons;
        logic [3:0] p2_buttons;
        logic       service;
    } player_in_t;

    typedef struct packed {
        logic [1:0] spare;
        logic       bank;
        logic       brq_n;
        logic       cblk;
        logic       soft_nl_n;
        logic       coin1;
        logic       coin0;
    } sys_flags_t;

    // Flag byte, written raw by the CPU, read back as fields
    typedef union packed {
        logic [7:0] raw;
        sys_flags_t fields;
    } sys_flags_u;

endpackage

/* verilog/m72_io_decode.sv */
//====================================================================
// Port request decode, one cycle. Word selects only on reads
// MCU_LATCH_PORT must lie above 0x05
//====================================================================
`timescale 1ns/1ps

module m72_io_decode #(
    parameter logic [7:0] MCU_LATCH_PORT = 8'hC0
) (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  m72_io_pkg::io_req_t io,
    output m72_io_pkg::io_sel_t sel
);

    m72_io_pkg::io_sel_t sel_next;
    logic [7:0] word_addr;

    assign word_addr = {io.addr[7:1], 1'b0};   // Bit 0 picks the byte

    always_comb begin
        sel_next              = '0;
        sel_next.rd           = io.rd;
        sel_next.wr           = io.wr;
        sel_next.hi_byte      = io.addr[0];
        sel_next.wdata        = io.data;
        sel_next.sel_sw       = io.rd && (word_addr == m72_io_pkg::PORT_SW);
        sel_next.sel_flag     = io.rd && (word_addr == m72_io_pkg::PORT_FLAG);
        sel_next.sel_dsw      = io.rd && (word_addr == m72_io_pkg::PORT_DSW);
        sel_next.sel_fset     = io.wr && (io.addr == m72_io_pkg::PORT_FSET);
        sel_next.sel_mculatch = io.wr && (io.addr == MCU_LATCH_PORT);
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sel <= '0;
        end else begin
            sel <= sel_next;
        end
    end

    //====================================================================
    // Checks
    //====================================================================

    // Bus never issues read and write together
    assert property (@(posedge CLK_32M) disable iff (!reset_n)
        !(io.rd && io.wr))
        else $error("m72_io_decode: rd and wr both high");

    // Downstream stages rely on a single active select
    assert property (@(posedge CLK_32M) disable iff (!reset_n)
        $onehot0({sel.sel_sw, sel.sel_flag, sel.sel_dsw,
                  sel.sel_fset, sel.sel_mculatch}))
        else $error("m72_io_decode: more than one select active");

endmodule

/* verilog/m72_io_sys_flags.sv */
//====================================================================
// System flag register and MCU latch, both loaded from the decoded bus
// Strobe is one cycle per latch write
//====================================================================
`timescale 1ns/1ps

module m72_sys_flags (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  m72_io_pkg::io_sel_t sel,
    input  logic                dip_sw8,
    output logic [1:0]          coin_counter,
    output logic                cblk,
    output logic                brq,
    output logic                bank,
    output logic                nl,
    output logic [7:0]          mcu_latch_data,
    output logic                mcu_latch_strobe
);

    m72_io_pkg::sys_flags_u flags;

    //====================================================================
    // Registers
    //====================================================================

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            flags.raw        <= 8'h00;
            mcu_latch_strobe <= 1'b0;
        end else begin
            if (sel.sel_fset) flags.raw <= sel.wdata;
            mcu_latch_strobe <= sel.sel_mculatch;
        end
    end

    // Latch payload
    always_ff @(posedge CLK_32M) begin
        if (sel.sel_mculatch) begin
            mcu_latch_data <= sel.wdata;
        end
    end

    //====================================================================
    // Derived control outputs
    //====================================================================

    assign coin_counter = {flags.fields.coin1, flags.fields.coin0};
    assign cblk         = flags.fields.cblk;
    assign brq          = ~flags.fields.brq_n;
    assign bank         = flags.fields.bank;

    // DIP bit 8 flips the screen orientation
    assign nl = ~flags.fields.soft_nl_n ^ dip_sw8;

    // MCU side samples one strobe per command byte
    assert property (@(posedge CLK_32M) disable iff (!reset_n)
        mcu_latch_strobe |=> !mcu_latch_strobe)
        else $error("m72_sys_flags: latch strobe held two cycles");

endmodule

/* verilog/m72_io_read.sv */
//====================================================================
// Read data mux. Byte lane from address bit 0
// Unmapped ports return the idle byte
//====================================================================
`timescale 1ns/1ps

module m72_io_read (
    input  logic                   CLK_32M,
    input  logic                   reset_n,
    input  m72_io_pkg::io_sel_t    sel,
    input  m72_io_pkg::player_in_t player,
    input  logic [15:0]            dip_sw,
    input  logic                   tnsl,
    output logic [7:0]             rd_data,
    output logic                   rd_valid
);

    logic [15:0] sw_word;
    logic [15:0] flag_word;
    logic [15:0] word;
    logic [7:0]  rd_byte;

    assign sw_word = {player.p2_buttons, player.p2_joystick,
                      player.p1_buttons, player.p1_joystick};

    // Test and R inputs tied off
    assign flag_word = {8'hFF, tnsl, 3'b111, player.coin, player.start};

    always_comb begin
        word = {m72_io_pkg::IO_IDLE_BYTE, m72_io_pkg::IO_IDLE_BYTE};
        if (sel.sel_sw) begin
            word = sw_word;
        end else if (sel.sel_flag) begin
            word = flag_word;
        end else if (sel.sel_dsw) begin
            word = dip_sw;
        end
        rd_byte = sel.hi_byte ? word[15:8] : word[7:0];
    end

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= sel.rd;
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (sel.rd) rd_data <= rd_byte;   // Held between reads
    end

    // Every byte handed to the CPU comes from driven inputs
    assert property (@(posedge CLK_32M) disable iff (!reset_n)
        rd_valid |-> !$isunknown(rd_data))
        else $error("m72_io_read: rd_data unknown on a valid read");

endmodule

/* verilog/m72_audio_mix.sv */
//====================================================================
// Unfiltered mix of YM music and MCU samples, one register stage
// MCU sample is offset binary, centred on 0x80
//====================================================================
`timescale 1ns/1ps

module m72_audio_mix (
    input  logic               CLK_32M,
    input  logic               reset_n,
    input  logic signed [15:0] ym_sample,
    input  logic [7:0]         mcu_sample,
    output logic [15:0]        audio_l,
    output logic [15:0]        audio_r
);

    logic [7:0]  mcu_signed;
    logic [16:0] mix_sum;
    logic [16:0] mix_q;

    assign mcu_signed = mcu_sample - 8'h80;   // Re-bias to two's complement

    // MCU sample sits at bits 16:9 of the sum
    assign mix_sum = {ym_sample[15], ym_sample} + {mcu_signed, 9'd0};

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            mix_q <= '0;
        end else begin
            mix_q <= mix_sum;
        end
    end

    // Mono, same on both channels
    assign audio_l = mix_q[16:1];
    assign audio_r = mix_q[16:1];

endmodule

/* verilog/m72_io_top.sv */
//====================================================================
// M72 main CPU port block and audio mixer
// Reads return two cycles after the strobe, no back-pressure
//====================================================================
`timescale 1ns/1ps

module m72_io_top #(
    parameter logic [7:0] MCU_LATCH_PORT = 8'hC0
) (
    input  logic                   CLK_32M,
    input  logic                   reset_n,
    input  m72_io_pkg::io_req_t    io,
    input  m72_io_pkg::player_in_t player,
    input  logic [15:0]            dip_sw,
    input  logic                   tnsl,
    input  logic signed [15:0]     ym_sample,
    input  logic [7:0]             mcu_sample,
    output logic [7:0]             rd_data,
    output logic                   rd_valid,
    output logic [1:0]             coin_counter,
    output logic                   cblk,
    output logic                   brq,
    output logic                   bank,
    output logic                   nl,
    output logic [7:0]             mcu_latch_data,
    output logic                   mcu_latch_strobe,
    output logic [15:0]            audio_l,
    output logic [15:0]            audio_r
);

    m72_io_pkg::io_sel_t sel;

    m72_io_decode #(
        .MCU_LATCH_PORT(MCU_LATCH_PORT)
    ) i_m72_io_decode (
        .CLK_32M (CLK_32M),
        .reset_n (reset_n),
        .io      (io),
        .sel     (sel)
    );

    m72_sys_flags i_m72_sys_flags (
        .CLK_32M          (CLK_32M),
        .reset_n          (reset_n),
        .sel              (sel),
        .dip_sw8          (dip_sw[8]),
        .coin_counter     (coin_counter),
        .cblk             (cblk),
        .brq              (brq),
        .bank             (bank),
        .nl               (nl),
        .mcu_latch_data   (mcu_latch_data),
        .mcu_latch_strobe (mcu_latch_strobe)
    );

    m72_io_read i_m72_io_read (
        .CLK_32M  (CLK_32M),
        .reset_n  (reset_n),
        .sel      (sel),
        .player   (player),
        .dip_sw   (dip_sw),
        .tnsl     (tnsl),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    // Audio path is independent of the port bus
    m72_audio_mix i_m72_audio_mix (
        .CLK_32M    (CLK_32M),
        .reset_n    (reset_n),
        .ym_sample  (ym_sample),
        .mcu_sample (mcu_sample),
        .audio_l    (audio_l),
        .audio_r    (audio_r)
    );

endmodule

/* testbench/tb_m72_io.sv */
//====================================================================
// Testbench for the M72 port block and audio mixer
// Read results are checked at a fixed 2-cycle latency
// Inputs stay steady while a read is in flight
//====================================================================
`timescale 1ns/1ps

module tb_m72_io;

    localparam logic [7:0] LATCH_PORT = 8'hC0;
    localparam int N_RD = 60;
    localparam int N_B2B = 50;
    localparam int N_FW = 32;
    localparam int N_LATCH = 16;
    localparam int N_AUD = 40;
    localparam int TEST_CYCLES = 4 + 3 * N_RD + N_B2B + 8 * N_FW + 4 * N_LATCH + 2 * N_AUD + 40;
    localparam int MARGIN = 200;

    typedef struct packed {
        logic [7:0]  data;
        logic [31:0] cyc;
    } exp_rd_t;

    typedef struct packed {
        logic [1:0] coin_counter;
        logic       cblk;
        logic       brq;
        logic       bank;
        logic       nl;
    } flag_out_t;

    logic CLK_32M;
    logic reset_n;
    m72_io_pkg::io_req_t    io;
    m72_io_pkg::player_in_t player;
    logic [15:0]        dip_sw;
    logic               tnsl;
    logic signed [15:0] ym_sample;
    logic [7:0]         mcu_sample;
    logic [7:0]  rd_data;
    logic        rd_valid;
    logic [1:0]  coin_counter;
    logic        cblk;
    logic        brq;
    logic        bank;
    logic        nl;
    logic [7:0]  mcu_latch_data;
    logic        mcu_latch_strobe;
    logic [15:0] audio_l;
    logic [15:0] audio_r;

    flag_out_t   dut_flags;
    exp_rd_t     exp_q[$];
    logic [31:0] cyc = 0;
    logic [31:0] rng = 32'd67;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    assign dut_flags = {coin_counter, cblk, brq, bank, nl};

    m72_io_top #(.MCU_LATCH_PORT(LATCH_PORT)) i_m72_io_top (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .io(io), .player(player),
        .dip_sw(dip_sw), .tnsl(tnsl), .ym_sample(ym_sample), .mcu_sample(mcu_sample),
        .rd_data(rd_data), .rd_valid(rd_valid), .coin_counter(coin_counter),
        .cblk(cblk), .brq(brq), .bank(bank), .nl(nl),
        .mcu_latch_data(mcu_latch_data), .mcu_latch_strobe(mcu_latch_strobe),
        .audio_l(audio_l), .audio_r(audio_r)
    );

    initial begin
        CLK_32M = 1'b0;
        forever #20 CLK_32M = ~CLK_32M;
    end

    always @(posedge CLK_32M) cyc <= cyc + 1;

    //====================================================================
    // Reference model
    //====================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [7:0] expected_read(input logic [7:0] addr,
            input m72_io_pkg::player_in_t p, input logic [15:0] dip, input logic t);
        logic [15:0] w;
        case (addr[7:1])
            7'h00:   w = {p.p2_buttons, p.p2_joystick, p.p1_buttons, p.p1_joystick};
            7'h01:   w = {8'hFF, t, 3'b111, p.coin, p.start};
            7'h02:   w = dip;
            default: w = 16'hFFFF;
        endcase
        return addr[0] ? w[15:8] : w[7:0];
    endfunction

    // Flag byte from the top is spare(2) bank brq_n cblk soft_nl_n coin1 coin0
    function automatic flag_out_t expected_flags(input logic [7:0] b, input logic dip8);
        flag_out_t f;
        f.coin_counter = b[1:0];
        f.cblk = b[3];
        f.brq  = ~b[4];
        f.bank = b[5];
        f.nl   = ~b[2] ^ dip8;
        return f;
    endfunction

    function automatic logic [15:0] expected_audio(input logic [15:0] ym, input logic [7:0] mcu);
        int s;
        int m;
        m = mcu;
        s = $signed(ym) + (m - 128) * 512;
        return s[16:1];
    endfunction

    //====================================================================
    // Reporting helpers
    //====================================================================

    task automatic note_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("Test %-12s %s", name, (errors == err_before) ? "ok" : "FAIL");
    endtask

    // One expected entry per valid pulse
    always @(negedge CLK_32M) begin
        exp_rd_t e;
        if (reset_n && rd_valid) begin
            if (exp_q.size() == 0) begin
                report_problem("rd_valid pulsed with no read outstanding");
            end else begin
                e = exp_q.pop_front();
                assert (rd_data == e.data && cyc == e.cyc)
                    else note_error($sformatf("read got %02h at cycle %0d, expected %02h at %0d",
                                              rd_data, cyc, e.data, e.cyc));
            end
        end
    end

    //====================================================================
    // Stimulus tasks on the falling edge
    //====================================================================

    task automatic issue_read(input logic [7:0] addr);
        exp_rd_t e;
        io.rd   = 1'b1;
        io.wr   = 1'b0;
        io.addr = addr;
        io.data = 8'h00;
        e.data  = expected_read(addr, player, dip_sw, tnsl);
        e.cyc   = cyc + 2;
        exp_q.push_back(e);
    endtask

    task automatic read_port(input logic [7:0] addr);
        @(negedge CLK_32M);
        issue_read(addr);
        @(negedge CLK_32M);
        io = '0;
        @(negedge CLK_32M);   // Inputs may change from here
    endtask

    task automatic wait_reads_done();
        repeat (4) @(negedge CLK_32M);
        if (exp_q.size() != 0) begin
            report_problem($sformatf("%0d read results never arrived", exp_q.size()));
            exp_q.delete();
        end
    endtask

    // Returns one cycle after the outputs update
    task automatic write_port(input logic [7:0] addr, input logic [7:0] data,
                              input logic expect_strobe, output flag_out_t flags_early,
                              output flag_out_t flags_late);
        @(negedge CLK_32M);
        io.rd   = 1'b0;
        io.wr   = 1'b1;
        io.addr = addr;
        io.data = data;
        @(negedge CLK_32M);
        io = '0;
        flags_early = dut_flags;
        assert (!mcu_latch_strobe) else note_error("latch strobe one cycle early");
        @(negedge CLK_32M);
        flags_late = dut_flags;
        assert (mcu_latch_strobe == expect_strobe &&
                (!expect_strobe || mcu_latch_data == data))
            else note_error($sformatf("port %02h write: strobe %b data %02h, expected %b %02h",
                                      addr, mcu_latch_strobe, mcu_latch_data,
                                      expect_strobe, data));
        @(negedge CLK_32M);
        assert (!mcu_latch_strobe) else note_error("latch strobe longer than one cycle");
    endtask

    //====================================================================
    // Test sequence
    //====================================================================

    initial begin
        logic [31:0] r;
        logic [7:0]  addr;
        logic [7:0]  new_flags;
        logic [7:0]  prev_flags;
        flag_out_t   f_early;
        flag_out_t   f_late;
        int err0;
        io = '0;
        player = '0;
        dip_sw = 16'h0000;
        tnsl = 1'b0;
        ym_sample = 16'sd0;
        mcu_sample = 8'h80;
        reset_n = 1'b0;
        repeat (4) @(posedge CLK_32M);
        @(negedge CLK_32M);
        reset_n = 1'b1;

        err0 = errors;
        @(negedge CLK_32M);
        assert (!rd_valid && !mcu_latch_strobe && dut_flags == expected_flags(8'h00, dip_sw[8]))
            else note_error("outputs not at their reset values");
        finish_test("reset", err0);

        err0 = errors;
        for (int i = 0; i < N_RD; i++) begin
            r = next_rand();
            player = r[20:0];
            tnsl = r[31];
            r = next_rand();
            dip_sw = r[15:0];
            addr = (i < 48) ? 8'(i % 6) : 8'(8'h06 + r[23:16] % 8'd250);
            read_port(addr);
        end
        wait_reads_done();
        finish_test("reads", err0);

        err0 = errors;
        for (int i = 0; i < N_B2B; i++) begin
            @(negedge CLK_32M);
            r = next_rand();
            issue_read({5'd0, r[2:0]});   // Ports 6 and 7 read as idle
        end
        @(negedge CLK_32M);
        io = '0;
        wait_reads_done();
        finish_test("back2back", err0);

        err0 = errors;
        prev_flags = 8'h00;
        for (int i = 0; i < N_FW; i++) begin
            r = next_rand();
            dip_sw = {r[31:25], 1'(i % 2), r[23:16]};
            new_flags = r[7:0];
            write_port(m72_io_pkg::PORT_FSET, new_flags, 1'b0, f_early, f_late);
            assert (f_early == expected_flags(prev_flags, dip_sw[8]) &&
                    f_late == expected_flags(new_flags, dip_sw[8]))
                else note_error($sformatf("flags %06b/%06b after write %02h, expected %06b/%06b",
                                          f_early, f_late, new_flags,
                                          expected_flags(prev_flags, dip_sw[8]),
                                          expected_flags(new_flags, dip_sw[8])));
            write_port(8'h01, r[15:8], 1'b0, f_early, f_late);
            assert (f_early == expected_flags(new_flags, dip_sw[8]) &&
                    f_late == expected_flags(new_flags, dip_sw[8]))
                else note_error("write to port 01 changed the flag outputs");
            prev_flags = new_flags;
        end
        finish_test("flags", err0);

        err0 = errors;
        for (int i = 0; i < N_LATCH; i++) begin
            r = next_rand();
            if (i % 2 == 0) begin
                write_port(LATCH_PORT, r[7:0], 1'b1, f_early, f_late);
            end else begin
                addr = r[15:8];
                if (addr == LATCH_PORT) addr = addr ^ 8'h01;
                write_port(addr, r[7:0], 1'b0, f_early, f_late);
            end
        end
        finish_test("mcu_latch", err0);

        err0 = errors;
        for (int i = 0; i < N_AUD; i++) begin
            @(negedge CLK_32M);
            r = next_rand();
            ym_sample = r[15:0];
            mcu_sample = r[23:16];
            @(negedge CLK_32M);
            assert (audio_l == expected_audio(ym_sample, mcu_sample) && audio_r == audio_l)
                else note_error($sformatf("audio ym %04h mcu %02h gave %04h/%04h, expected %04h",
                                          ym_sample, mcu_sample, audio_l, audio_r,
                                          expected_audio(ym_sample, mcu_sample)));
        end
        finish_test("audio", err0);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * 40);
        $display("Run timed out after %0d cycles without finishing", TEST_CYCLES + MARGIN);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* build.f */
verilog/m72_io_pkg.sv
verilog/m72_io_decode.sv
verilog/m72_io_sys_flags.sv
verilog/m72_io_read.sv
verilog/m72_audio_mix.sv
verilog/m72_io_top.sv
testbench/tb_m72_io.sv
